// File: hdl/wb_stream_pkg.sv
// wishbone stream subsystem package
// channel counts, queue sizing, bus width and address map

package wb_stream_pkg;

  // bus and stream word width
  localparam int WORD_W = 32;

  // channel counts, one sum channel per input/output pair
  localparam int NUM_ISTREAM = 2;
  localparam int NUM_OSTREAM = NUM_ISTREAM;

  // queue sizing
  localparam int QUEUE_DEPTH = 2;
  localparam int QUEUE_PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  ////////////////////
  // address map
  ////////////////////

  // each channel owns an 8-byte slot, status word then data word
  localparam int SLOT_BYTES = 8;
  localparam int SLOT_SHIFT = $clog2(SLOT_BYTES);

  localparam int ISTREAM_IDX_W = (NUM_ISTREAM > 1) ? $clog2(NUM_ISTREAM) : 1;
  localparam int OSTREAM_IDX_W = (NUM_OSTREAM > 1) ? $clog2(NUM_OSTREAM) : 1;

  localparam logic [WORD_W-1:0] ISTREAM_BASE = 32'h3000_0000;
  localparam logic [WORD_W-1:0] OSTREAM_BASE = ISTREAM_BASE + WORD_W'(SLOT_BYTES * NUM_ISTREAM);
  // first byte past the output region
  localparam logic [WORD_W-1:0] OSTREAM_END = OSTREAM_BASE + WORD_W'(SLOT_BYTES * NUM_OSTREAM);

  // offsets inside a slot
  localparam logic [WORD_W-1:0] STATUS_OFS = 32'd0;
  localparam logic [WORD_W-1:0] DATA_OFS = 32'd4;

endpackage

// File: hdl/stream_queue.sv
// two-entry valid/ready FIFO, normal mode
// circular buffer with read/write pointers and an entry count, no bypass

`timescale 1ns/10ps

module stream_queue (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             enq_val_i,
  output logic                             enq_rdy_o,
  input  logic [wb_stream_pkg::WORD_W-1:0] enq_msg_i,
  output logic                             deq_val_o,
  input  logic                             deq_rdy_i,
  output logic [wb_stream_pkg::WORD_W-1:0] deq_msg_o
);

  logic [wb_stream_pkg::WORD_W-1:0] mem [wb_stream_pkg::QUEUE_DEPTH];

  logic [wb_stream_pkg::QUEUE_PTR_W-1:0] wr_ptr;
  logic [wb_stream_pkg::QUEUE_PTR_W-1:0] rd_ptr;
  logic [wb_stream_pkg::QUEUE_CNT_W-1:0] count;

  logic enq_fire;
  logic deq_fire;

  // ready and valid come from the count only
  assign enq_rdy_o = (count < wb_stream_pkg::QUEUE_CNT_W'(wb_stream_pkg::QUEUE_DEPTH));
  assign deq_val_o = (count != '0);
  assign deq_msg_o = mem[rd_ptr];

  assign enq_fire = enq_val_i && enq_rdy_o;
  assign deq_fire = deq_val_o && deq_rdy_i;

  // storage
  always_ff @(posedge clk) begin
    if (enq_fire) begin
      mem[wr_ptr] <= enq_msg_i;
    end
  end

  // pointers and count
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire) begin
        if (wr_ptr == wb_stream_pkg::QUEUE_PTR_W'(wb_stream_pkg::QUEUE_DEPTH - 1)) begin
          wr_ptr <= '0;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
      if (deq_fire) begin
        if (rd_ptr == wb_stream_pkg::QUEUE_PTR_W'(wb_stream_pkg::QUEUE_DEPTH - 1)) begin
          rd_ptr <= '0;
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
      // simultaneous push and pop leaves count unchanged
      if (enq_fire && !deq_fire) begin
        count <= count + 1'b1;
      end else if (deq_fire && !enq_fire) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

// File: hdl/wb_stream_regs.sv
// wishbone slave for the stream subsystem
// decodes status/data slots, owns the input and output queues, drives read data

`timescale 1ns/10ps

module wb_stream_regs (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             wbs_stb_i,
  input  logic                             wbs_cyc_i,
  input  logic                             wbs_we_i,
  input  logic [wb_stream_pkg::WORD_W-1:0] wbs_adr_i,
  input  logic [wb_stream_pkg::WORD_W-1:0] wbs_dat_i,
  output logic                             wbs_ack_o,
  output logic [wb_stream_pkg::WORD_W-1:0] wbs_dat_o,
  output logic                             istream_val_o [wb_stream_pkg::NUM_ISTREAM],
  input  logic                             istream_rdy_i [wb_stream_pkg::NUM_ISTREAM],
  output logic [wb_stream_pkg::WORD_W-1:0] istream_data_o [wb_stream_pkg::NUM_ISTREAM],
  input  logic                             ostream_val_i [wb_stream_pkg::NUM_OSTREAM],
  output logic                             ostream_rdy_o [wb_stream_pkg::NUM_OSTREAM],
  input  logic [wb_stream_pkg::WORD_W-1:0] ostream_data_i [wb_stream_pkg::NUM_OSTREAM]
);

  ////////////////////
  // address decode
  ////////////////////

  logic xfer;
  logic in_region;
  logic out_region;
  logic is_status;
  logic is_data;

  logic [wb_stream_pkg::WORD_W-1:0] in_slot;
  logic [wb_stream_pkg::WORD_W-1:0] out_slot;
  logic [wb_stream_pkg::ISTREAM_IDX_W-1:0] in_idx;
  logic [wb_stream_pkg::OSTREAM_IDX_W-1:0] out_idx;

  logic in_status_rd;
  logic in_data_wr;
  logic out_status_rd;
  logic out_data_rd;

  // single-cycle transfers, ack follows the strobe
  assign xfer      = wbs_stb_i && wbs_cyc_i;
  assign wbs_ack_o = xfer;

  assign in_region  = (wbs_adr_i >= wb_stream_pkg::ISTREAM_BASE)
                   && (wbs_adr_i < wb_stream_pkg::OSTREAM_BASE);
  assign out_region = (wbs_adr_i >= wb_stream_pkg::OSTREAM_BASE)
                   && (wbs_adr_i < wb_stream_pkg::OSTREAM_END);

  assign is_status = (wbs_adr_i[wb_stream_pkg::SLOT_SHIFT-1:0]
                   == wb_stream_pkg::STATUS_OFS[wb_stream_pkg::SLOT_SHIFT-1:0]);
  assign is_data   = (wbs_adr_i[wb_stream_pkg::SLOT_SHIFT-1:0]
                   == wb_stream_pkg::DATA_OFS[wb_stream_pkg::SLOT_SHIFT-1:0]);

  // channel index is the slot number within its region
  assign in_slot  = (wbs_adr_i - wb_stream_pkg::ISTREAM_BASE) >> wb_stream_pkg::SLOT_SHIFT;
  assign out_slot = (wbs_adr_i - wb_stream_pkg::OSTREAM_BASE) >> wb_stream_pkg::SLOT_SHIFT;
  assign in_idx   = in_slot[wb_stream_pkg::ISTREAM_IDX_W-1:0];
  assign out_idx  = out_slot[wb_stream_pkg::OSTREAM_IDX_W-1:0];

  assign in_status_rd  = xfer && !wbs_we_i && in_region && is_status;
  assign in_data_wr    = xfer && wbs_we_i && in_region && is_data;
  assign out_status_rd = xfer && !wbs_we_i && out_region && is_status;
  assign out_data_rd   = xfer && !wbs_we_i && out_region && is_data;

  ////////////////////
  // input queues
  ////////////////////

  logic in_enq_val [wb_stream_pkg::NUM_ISTREAM];
  logic in_enq_rdy [wb_stream_pkg::NUM_ISTREAM];

  for (genvar i = 0; i < wb_stream_pkg::NUM_ISTREAM; i++) begin : g_in_q
    // a write to a full queue is simply not taken
    assign in_enq_val[i] = in_data_wr && (in_idx == wb_stream_pkg::ISTREAM_IDX_W'(i));

    stream_queue in_q (
      .clk       (clk),
      .reset_i   (reset_i),
      .enq_val_i (in_enq_val[i]),
      .enq_rdy_o (in_enq_rdy[i]),
      .enq_msg_i (wbs_dat_i),
      .deq_val_o (istream_val_o[i]),
      .deq_rdy_i (istream_rdy_i[i]),
      .deq_msg_o (istream_data_o[i])
    );
  end

  ////////////////////
  // output queues
  ////////////////////

  logic                             out_deq_val [wb_stream_pkg::NUM_OSTREAM];
  logic                             out_deq_rdy [wb_stream_pkg::NUM_OSTREAM];
  logic [wb_stream_pkg::WORD_W-1:0] out_deq_msg [wb_stream_pkg::NUM_OSTREAM];

  for (genvar i = 0; i < wb_stream_pkg::NUM_OSTREAM; i++) begin : g_out_q
    // pop only when a word is actually there
    assign out_deq_rdy[i] = out_data_rd && out_deq_val[i]
                         && (out_idx == wb_stream_pkg::OSTREAM_IDX_W'(i));

    stream_queue out_q (
      .clk       (clk),
      .reset_i   (reset_i),
      .enq_val_i (ostream_val_i[i]),
      .enq_rdy_o (ostream_rdy_o[i]),
      .enq_msg_i (ostream_data_i[i]),
      .deq_val_o (out_deq_val[i]),
      .deq_rdy_i (out_deq_rdy[i]),
      .deq_msg_o (out_deq_msg[i])
    );
  end

  // read data mux, zero for anything unmapped
  always_comb begin
    wbs_dat_o = '0;
    if (in_status_rd) begin
      wbs_dat_o = {{(wb_stream_pkg::WORD_W-1){1'b0}}, in_enq_rdy[in_idx]};
    end else if (out_status_rd) begin
      wbs_dat_o = {{(wb_stream_pkg::WORD_W-1){1'b0}}, out_deq_val[out_idx]};
    end else if (out_data_rd && out_deq_val[out_idx]) begin
      wbs_dat_o = out_deq_msg[out_idx];
    end
  end

endmodule

// File: hdl/stream_accum.sv
// per-channel running-sum engine
// adds each accepted input word to its channel sum and offers the new sum

`timescale 1ns/10ps

module stream_accum (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             in_val_i [wb_stream_pkg::NUM_ISTREAM],
  output logic                             in_rdy_o [wb_stream_pkg::NUM_ISTREAM],
  input  logic [wb_stream_pkg::WORD_W-1:0] in_data_i [wb_stream_pkg::NUM_ISTREAM],
  output logic                             out_val_o [wb_stream_pkg::NUM_OSTREAM],
  input  logic                             out_rdy_i [wb_stream_pkg::NUM_OSTREAM],
  output logic [wb_stream_pkg::WORD_W-1:0] out_data_o [wb_stream_pkg::NUM_OSTREAM]
);

  // the sum register doubles as the output data register
  logic [wb_stream_pkg::WORD_W-1:0] sum_q [wb_stream_pkg::NUM_OSTREAM];
  logic                             out_val_q [wb_stream_pkg::NUM_OSTREAM];
  logic                             in_fire [wb_stream_pkg::NUM_ISTREAM];

  for (genvar c = 0; c < wb_stream_pkg::NUM_ISTREAM; c++) begin : g_chan
    // room when the register is empty or draining this cycle
    assign in_rdy_o[c] = !out_val_q[c] || out_rdy_i[c];
    assign in_fire[c]  = in_val_i[c] && in_rdy_o[c];

    assign out_val_o[c]  = out_val_q[c];
    assign out_data_o[c] = sum_q[c];

    always_ff @(posedge clk) begin
      if (reset_i) begin
        sum_q[c]     <= '0;
        out_val_q[c] <= 1'b0;
      end else begin
        if (in_fire[c]) begin
          // wraps modulo 2^WORD_W
          sum_q[c]     <= sum_q[c] + in_data_i[c];
          out_val_q[c] <= 1'b1;
        end else if (out_rdy_i[c]) begin
          out_val_q[c] <= 1'b0;
        end
      end
    end
  end

endmodule

// File: hdl/wb_stream_top.sv
// stream subsystem top level
// wishbone slave block feeding the running-sum engine and back

`timescale 1ns/10ps

module wb_stream_top (
  input  logic                             clk,
  input  logic                             reset_i,
  input  logic                             wbs_stb_i,
  input  logic                             wbs_cyc_i,
  input  logic                             wbs_we_i,
  input  logic [wb_stream_pkg::WORD_W-1:0] wbs_adr_i,
  input  logic [wb_stream_pkg::WORD_W-1:0] wbs_dat_i,
  output logic                             wbs_ack_o,
  output logic [wb_stream_pkg::WORD_W-1:0] wbs_dat_o
);

  // regs to accum
  logic                             istream_val [wb_stream_pkg::NUM_ISTREAM];
  logic                             istream_rdy [wb_stream_pkg::NUM_ISTREAM];
  logic [wb_stream_pkg::WORD_W-1:0] istream_data [wb_stream_pkg::NUM_ISTREAM];

  // accum back to regs
  logic                             ostream_val [wb_stream_pkg::NUM_OSTREAM];
  logic                             ostream_rdy [wb_stream_pkg::NUM_OSTREAM];
  logic [wb_stream_pkg::WORD_W-1:0] ostream_data [wb_stream_pkg::NUM_OSTREAM];

  wb_stream_regs wb_stream_regs_inst (
    .clk            (clk),
    .reset_i        (reset_i),
    .wbs_stb_i      (wbs_stb_i),
    .wbs_cyc_i      (wbs_cyc_i),
    .wbs_we_i       (wbs_we_i),
    .wbs_adr_i      (wbs_adr_i),
    .wbs_dat_i      (wbs_dat_i),
    .wbs_ack_o      (wbs_ack_o),
    .wbs_dat_o      (wbs_dat_o),
    .istream_val_o  (istream_val),
    .istream_rdy_i  (istream_rdy),
    .istream_data_o (istream_data),
    .ostream_val_i  (ostream_val),
    .ostream_rdy_o  (ostream_rdy),
    .ostream_data_i (ostream_data)
  );

  stream_accum stream_accum_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_val_i   (istream_val),
    .in_rdy_o   (istream_rdy),
    .in_data_i  (istream_data),
    .out_val_o  (ostream_val),
    .out_rdy_i  (ostream_rdy),
    .out_data_o (ostream_data)
  );

endmodule

// File: verification/wb_stream_asserts.sv
// protocol checks on the wishbone slave and its stream handshakes
// bound into wb_stream_regs

`timescale 1ns/10ps

module wb_stream_asserts (
  input logic                             clk,
  input logic                             reset_i,
  input logic                             wbs_stb_i,
  input logic                             wbs_cyc_i,
  input logic                             wbs_ack_o,
  input logic                             istream_val_o [wb_stream_pkg::NUM_ISTREAM],
  input logic                             istream_rdy_i [wb_stream_pkg::NUM_ISTREAM],
  input logic [wb_stream_pkg::WORD_W-1:0] istream_data_o [wb_stream_pkg::NUM_ISTREAM],
  input logic                             ostream_val_i [wb_stream_pkg::NUM_OSTREAM],
  input logic                             ostream_rdy_o [wb_stream_pkg::NUM_OSTREAM],
  input logic [wb_stream_pkg::WORD_W-1:0] ostream_data_i [wb_stream_pkg::NUM_OSTREAM],
  input logic                             out_deq_val [wb_stream_pkg::NUM_OSTREAM]
);

  // failure tally
  int fail_count = 0;

  a_ack: assert property (@(posedge clk) wbs_ack_o == (wbs_stb_i && wbs_cyc_i))
    else begin
      fail_count++;
      $error("wbs_ack_o differs from stb and cyc");
    end

  for (genvar i = 0; i < wb_stream_pkg::NUM_ISTREAM; i++) begin : g_in
    // stalled word stays put
    a_in_hold: assert property (@(posedge clk) disable iff (reset_i)
      istream_val_o[i] && !istream_rdy_i[i] |=> istream_val_o[i] && $stable(istream_data_o[i]))
      else begin
        fail_count++;
        $error("input stream %0d dropped or changed a stalled word", i);
      end
  end

  for (genvar i = 0; i < wb_stream_pkg::NUM_OSTREAM; i++) begin : g_out
    a_out_hold: assert property (@(posedge clk) disable iff (reset_i)
      ostream_val_i[i] && !ostream_rdy_o[i] |=> ostream_val_i[i] && $stable(ostream_data_i[i]))
      else begin
        fail_count++;
        $error("output stream %0d dropped or changed a stalled word", i);
      end

    // an empty queue stays empty unless a word is enqueued
    a_no_empty_pop: assert property (@(posedge clk) disable iff (reset_i)
      !out_deq_val[i] && !(ostream_val_i[i] && ostream_rdy_o[i]) |=> !out_deq_val[i])
      else begin
        fail_count++;
        $error("output queue %0d showed data with nothing enqueued", i);
      end
  end

endmodule

bind wb_stream_regs wb_stream_asserts wb_stream_asserts_inst (
  .clk            (clk),
  .reset_i        (reset_i),
  .wbs_stb_i      (wbs_stb_i),
  .wbs_cyc_i      (wbs_cyc_i),
  .wbs_ack_o      (wbs_ack_o),
  .istream_val_o  (istream_val_o),
  .istream_rdy_i  (istream_rdy_i),
  .istream_data_o (istream_data_o),
  .ostream_val_i  (ostream_val_i),
  .ostream_rdy_o  (ostream_rdy_o),
  .ostream_data_i (ostream_data_i),
  .out_deq_val    (out_deq_val)
);

// File: verification/wb_stream_tb.sv
// testbench for the wishbone stream subsystem
// seeded random bus traffic checked against a per-channel running-sum model

`timescale 1ns/10ps

module wb_stream_tb;

  localparam int TEST_CYCLES = 1500;
  localparam int POLL_LIMIT  = 40;
  localparam int RAND_OPS    = 300;

  logic        clk;
  logic        reset_i;
  logic        wbs_stb_i;
  logic        wbs_cyc_i;
  logic        wbs_we_i;
  logic [31:0] wbs_adr_i;
  logic [31:0] wbs_dat_i;
  logic        wbs_ack_o;
  logic [31:0] wbs_dat_o;

  int seed;
  int tests;
  int checks;
  int errors;

  // running totals and expected sums per channel, oldest first
  logic [31:0] sum_model [2];
  logic [31:0] exp_q0 [$];
  logic [31:0] exp_q1 [$];

  wb_stream_top wb_stream_top_inst (
    .clk       (clk),
    .reset_i   (reset_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_we_i  (wbs_we_i),
    .wbs_adr_i (wbs_adr_i),
    .wbs_dat_i (wbs_dat_i),
    .wbs_ack_o (wbs_ack_o),
    .wbs_dat_o (wbs_dat_o)
  );

  always #2 clk = ~clk;

  // watchdog, four times the expected test length
  initial begin
    #(TEST_CYCLES * 4 * 4);
    $display("watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  ////////////////////
  // bus access
  ////////////////////

  // called 1 ns after a rising edge, returns 1 ns after the edge that took the transfer
  task automatic bus_access(input logic we, input logic [31:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int waits;
    waits     = 0;
    wbs_stb_i = 1'b1;
    wbs_cyc_i = 1'b1;
    wbs_we_i  = we;
    wbs_adr_i = adr;
    wbs_dat_i = wdata;
    @(negedge clk);
    while (!wbs_ack_o && waits < POLL_LIMIT) begin
      waits++;
      @(negedge clk);
    end
    if (!wbs_ack_o) begin
      errors++;
      $display("no acknowledge for the access at address %h", adr);
    end
    rdata = wbs_dat_o;
    @(posedge clk);
    #1;
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    wbs_we_i  = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] adr, input logic [31:0] data);
    logic [31:0] ignored;
    bus_access(1'b1, adr, data, ignored);
  endtask

  task automatic bus_read(input logic [31:0] adr, output logic [31:0] data);
    bus_access(1'b0, adr, 32'h0, data);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // 8-byte slot per channel
  function automatic logic [31:0] istream_addr(input int c, input logic [31:0] ofs);
    return wb_stream_pkg::ISTREAM_BASE + 32'(8 * c) + ofs;
  endfunction

  function automatic logic [31:0] ostream_addr(input int c, input logic [31:0] ofs);
    return wb_stream_pkg::OSTREAM_BASE + 32'(8 * c) + ofs;
  endfunction

  // addresses outside the map or off the word offsets
  function automatic logic [31:0] stray_addr(input int k);
    case (k)
      0: return wb_stream_pkg::ISTREAM_BASE - 32'd4;
      1: return wb_stream_pkg::OSTREAM_BASE + 32'd16;
      2: return wb_stream_pkg::OSTREAM_BASE + 32'd20;
      3: return 32'h0;
      4: return istream_addr(0, 32'd1);
      5: return istream_addr(1, 32'd6);
      6: return ostream_addr(0, 32'd2);
      7: return ostream_addr(1, 32'd7);
      default: return 32'hffff_fff8;
    endcase
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  task automatic model_accept(input int c, input logic [31:0] word);
    sum_model[c[0]] = sum_model[c[0]] + word;
    if (c == 0) begin
      exp_q0.push_back(sum_model[c[0]]);
    end else begin
      exp_q1.push_back(sum_model[c[0]]);
    end
  endtask

  function automatic int pending(input int c);
    return (c == 0) ? exp_q0.size() : exp_q1.size();
  endfunction

  task automatic model_next(input int c, output logic [31:0] expected);
    if (c == 0) begin
      expected = exp_q0.pop_front();
    end else begin
      expected = exp_q1.pop_front();
    end
  endtask

  // a write goes out only after the status read says there is room
  task automatic write_checked(input int c, input logic [31:0] word, output logic taken);
    logic [31:0] st;
    bus_read(istream_addr(c, wb_stream_pkg::STATUS_OFS), st);
    taken = st[0];
    if (taken) begin
      bus_write(istream_addr(c, wb_stream_pkg::DATA_OFS), word);
      model_accept(c, word);
    end
  endtask

  task automatic wait_output(input int c, output logic seen);
    logic [31:0] st;
    int          polls;
    polls = 0;
    bus_read(ostream_addr(c, wb_stream_pkg::STATUS_OFS), st);
    while (!st[0] && polls < POLL_LIMIT) begin
      polls++;
      bus_read(ostream_addr(c, wb_stream_pkg::STATUS_OFS), st);
    end
    seen = st[0];
  endtask

  task automatic pop_checked(input int c);
    logic        seen;
    logic [31:0] data;
    logic [31:0] expected;
    wait_output(c, seen);
    model_next(c, expected);
    if (!seen) begin
      errors++;
      $display("output channel %0d held no data after %0d status polls", c, POLL_LIMIT);
    end else begin
      bus_read(ostream_addr(c, wb_stream_pkg::DATA_OFS), data);
      check_value($sformatf("wbs_dat_o output %0d", c), expected, data);
    end
  endtask

  task automatic drain(input int c);
    logic [31:0] st;
    while (pending(c) > 0) begin
      pop_checked(c);
    end
    bus_read(ostream_addr(c, wb_stream_pkg::STATUS_OFS), st);
    check_value($sformatf("wbs_dat_o output %0d status", c), 32'h0, st);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests++;
    $display("test %0d %s finished with %0d errors", tests, name, errors - errs_before);
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    int          errs_before;
    int          c;
    int          k;
    int          zeros;
    int          tries;
    logic        taken;
    logic [31:0] rnd;
    logic [31:0] word;
    logic [31:0] rdata;

    clk          = 1'b0;
    reset_i      = 1'b1;
    wbs_stb_i    = 1'b0;
    wbs_cyc_i    = 1'b0;
    wbs_we_i     = 1'b0;
    wbs_adr_i    = 32'h0;
    wbs_dat_i    = 32'h0;
    seed         = 32'h7e159cf3;
    tests        = 0;
    checks       = 0;
    errors       = 0;
    sum_model[0] = 32'h0;
    sum_model[1] = 32'h0;
    repeat (16) @(posedge clk);
    #1;
    reset_i = 1'b0;

    errs_before = errors;
    for (c = 0; c < 2; c++) begin
      bus_read(istream_addr(c, wb_stream_pkg::STATUS_OFS), rdata);
      check_value("wbs_dat_o input status", 32'h1, rdata);
      bus_read(ostream_addr(c, wb_stream_pkg::STATUS_OFS), rdata);
      check_value("wbs_dat_o output status", 32'h0, rdata);
      bus_read(ostream_addr(c, wb_stream_pkg::DATA_OFS), rdata);
      check_value("wbs_dat_o output data", 32'h0, rdata);
      bus_read(istream_addr(c, wb_stream_pkg::DATA_OFS), rdata);
      check_value("wbs_dat_o input data", 32'h0, rdata);
    end
    report_test("reset state", errs_before);

    // sums start at zero so the first sum is the word itself
    errs_before = errors;
    for (c = 0; c < 2; c++) begin
      word = $random(seed);
      write_checked(c, word, taken);
      check_value("wbs_dat_o input status", 32'h1, {31'b0, taken});
      drain(c);
    end
    report_test("single word", errs_before);

    errs_before = errors;
    for (tries = 0; tries < RAND_OPS; tries++) begin
      rnd = $random(seed);
      c   = rnd[0] ? 1 : 0;
      if (rnd[1]) begin
        word = $random(seed);
        write_checked(c, word, taken);
      end else begin
        bus_read(ostream_addr(c, wb_stream_pkg::STATUS_OFS), rdata);
        if (rdata[0] && pending(c) == 0) begin
          errors++;
          $display("output channel %0d showed data with no accepted write behind it", c);
        end else if (rdata[0]) begin
          pop_checked(c);
        end
      end
    end
    drain(0);
    drain(1);
    report_test("random words", errs_before);

    // two refused status reads in a row mean the whole path is stalled
    errs_before = errors;
    for (c = 0; c < 2; c++) begin
      zeros = 0;
      tries = 0;
      while (zeros < 2 && tries < 20) begin
        word = $random(seed);
        write_checked(c, word, taken);
        zeros = taken ? 0 : zeros + 1;
        tries++;
      end
      // input queue, sum register and output queue
      check_value("accepted word count", 32'd5, 32'(pending(c)));
      repeat (3) begin
        word = $random(seed);
        bus_write(istream_addr(c, wb_stream_pkg::DATA_OFS), word);
      end
      bus_read(istream_addr(c, wb_stream_pkg::STATUS_OFS), rdata);
      check_value("wbs_dat_o input status", 32'h0, rdata);
      drain(c);
    end
    report_test("back-pressure", errs_before);

    // park a word per channel so a misdecoded read would expose it
    errs_before = errors;
    for (c = 0; c < 2; c++) begin
      word = $random(seed);
      write_checked(c, word, taken);
      wait_output(c, taken);
    end
    for (k = 0; k < 9; k++) begin
      bus_read(stray_addr(k), rdata);
      check_value($sformatf("wbs_dat_o stray read %h", stray_addr(k)), 32'h0, rdata);
      word = $random(seed);
      bus_write(stray_addr(k), word);
    end
    for (c = 0; c < 2; c++) begin
      bus_write(ostream_addr(c, wb_stream_pkg::DATA_OFS), $random(seed));
      bus_write(ostream_addr(c, wb_stream_pkg::STATUS_OFS), $random(seed));
      bus_write(istream_addr(c, wb_stream_pkg::STATUS_OFS), $random(seed));
      word = $random(seed);
      write_checked(c, word, taken);
      drain(c);
    end
    report_test("unmapped access", errs_before);

    errors = errors + wb_stream_top_inst.wb_stream_regs_inst.wb_stream_asserts_inst.fail_count;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: compile.f
hdl/wb_stream_pkg.sv
hdl/stream_queue.sv
hdl/wb_stream_regs.sv
hdl/stream_accum.sv
hdl/wb_stream_top.sv
verification/wb_stream_asserts.sv
verification/wb_stream_tb.sv

// File: Makefile
# Verilator build and run of the stream subsystem testbench

VERILATOR ?= verilator
TOP       ?= wb_stream_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIMFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
